// File: rv64_pkg.sv
`default_nettype none

package rv64_pkg;

  // Integer register file geometry
  localparam int dword_width_lp    = 64;
  localparam int reg_addr_width_lp = 5;

  // Shift amounts use the low six bits of rs2 on RV64
  localparam int shamt_width_lp    = 6;

  typedef logic [dword_width_lp-1:0]    dword_t;
  typedef logic [reg_addr_width_lp-1:0] reg_addr_t;

  // Hard-wired zero register
  localparam reg_addr_t x0_addr_lp = '0;

endpackage

`default_nettype wire

// File: calc_pkg.sv
`default_nettype none

package calc_pkg;

  // Cycles from the reservation register until each pipe's result is valid
  localparam int int_latency_lp = 1;
  localparam int mul_latency_lp = 3;

  // Completion stages after the reservation slot, the last one is writeback
  localparam int comp_stages_lp = 4;

  // Dispatch edge to writeback output
  localparam int wb_latency_lp  = 4;

  typedef enum logic [3:0]
  {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_sll = 4'd5,
    op_srl = 4'd6,
    op_slt = 4'd7,
    op_mul = 4'd8
  } alu_op_e;

  // Per-stage bookkeeping carried alongside the result word
  typedef struct packed
  {
    logic                valid;
    logic                poison;
    logic                is_mul;
    logic                irf_w;
    rv64_pkg::reg_addr_t rd_addr;
  } stage_meta_s;

endpackage

`default_nettype wire

// File: operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
  (input  wire                                             clk_i,
   input  wire                                             arst_n_i,
   input  calc_pkg::alu_op_e                               dispatch_op_i,
   input  rv64_pkg::reg_addr_t                             dispatch_rs1_addr_i,
   input  rv64_pkg::reg_addr_t                             dispatch_rs2_addr_i,
   input  rv64_pkg::dword_t                                dispatch_rs1_i,
   input  rv64_pkg::dword_t                                dispatch_rs2_i,
   input  logic                [calc_pkg::comp_stages_lp:1] fwd_v_i,
   input  rv64_pkg::reg_addr_t [calc_pkg::comp_stages_lp:1] fwd_rd_addr_i,
   input  rv64_pkg::dword_t    [calc_pkg::comp_stages_lp:1] fwd_data_i,
   output calc_pkg::alu_op_e                               rsv_op_o,
   output rv64_pkg::dword_t                                rsv_rs1_o,
   output rv64_pkg::dword_t                                rsv_rs2_o
  );

  rv64_pkg::dword_t bypass_rs1;
  rv64_pkg::dword_t bypass_rs2;
  logic             hazard;

  // Scan from the oldest stage down so the youngest match is the one kept
  function automatic rv64_pkg::dword_t bypass_operand(input rv64_pkg::reg_addr_t addr,
                                                      input rv64_pkg::dword_t    value);
    rv64_pkg::dword_t result;
    result = value;
    for (int k = calc_pkg::comp_stages_lp; k >= 1; k--)
    begin
      if (fwd_v_i[k] && (fwd_rd_addr_i[k] == addr))
      begin
        result = fwd_data_i[k];
      end
    end
    // x0 reads zero no matter what is in flight
    if (addr == rv64_pkg::x0_addr_lp)
    begin
      result = '0;
    end
    return result;
  endfunction

  always_comb
  begin
    bypass_rs1 = bypass_operand(dispatch_rs1_addr_i, dispatch_rs1_i);
    bypass_rs2 = bypass_operand(dispatch_rs2_addr_i, dispatch_rs2_i);
  end

  // Reservation register, one cycle ahead of both execution pipes
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsv_op_o  <= calc_pkg::op_add;
      rsv_rs1_o <= '0;
      rsv_rs2_o <= '0;
    end
    else
    begin
      rsv_op_o  <= dispatch_op_i;
      rsv_rs1_o <= bypass_rs1;
      rsv_rs2_o <= bypass_rs2;
    end
  end

  // A live stage without its result still shows a non-zero rd
  always_comb
  begin
    hazard = 1'b0;
    for (int k = 1; k <= calc_pkg::comp_stages_lp; k++)
    begin
      if (!fwd_v_i[k] && (fwd_rd_addr_i[k] != rv64_pkg::x0_addr_lp)
          && ((fwd_rd_addr_i[k] == dispatch_rs1_addr_i)
              || (fwd_rd_addr_i[k] == dispatch_rs2_addr_i)))
      begin
        hazard = 1'b1;
      end
    end
  end

  // Dispatcher must hold a consumer back until the multiply result exists
  a_no_early_consumer : assert property (@(posedge clk_i) disable iff (!arst_n_i) !hazard)
    else $error("operand_bypass: source operand depends on an unfinished multiply");

endmodule

`default_nettype wire

// File: pipe_int.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_int
  (input  wire               clk_i,
   input  wire               arst_n_i,
   input  calc_pkg::alu_op_e op_i,
   input  rv64_pkg::dword_t  rs1_i,
   input  rv64_pkg::dword_t  rs2_i,
   output rv64_pkg::dword_t  data_o
  );

  rv64_pkg::dword_t                   result;
  logic [rv64_pkg::shamt_width_lp-1:0] shamt;
  logic                               less_than;

  assign shamt     = rs2_i[rv64_pkg::shamt_width_lp-1:0];
  assign less_than = $signed(rs1_i) < $signed(rs2_i);

  always_comb
  begin
    case (op_i)
      calc_pkg::op_add: result = rs1_i + rs2_i;
      calc_pkg::op_sub: result = rs1_i - rs2_i;
      calc_pkg::op_and: result = rs1_i & rs2_i;
      calc_pkg::op_or:  result = rs1_i | rs2_i;
      calc_pkg::op_xor: result = rs1_i ^ rs2_i;
      calc_pkg::op_sll: result = rs1_i << shamt;
      calc_pkg::op_srl: result = rs1_i >> shamt;
      calc_pkg::op_slt: result = rv64_pkg::dword_t'(less_than);
      // Multiplies are computed in pipe_mul
      default:          result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      data_o <= '0;
    end
    else
    begin
      data_o <= result;
    end
  end

endmodule

`default_nettype wire

// File: pipe_mul.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_mul
  (input  wire              clk_i,
   input  wire              arst_n_i,
   input  rv64_pkg::dword_t rs1_i,
   input  rv64_pkg::dword_t rs2_i,
   output rv64_pkg::dword_t data_o
  );

  rv64_pkg::dword_t                          a_r;
  rv64_pkg::dword_t                          b_r;
  rv64_pkg::dword_t                          lo_prod_r;
  logic [rv64_pkg::dword_width_lp/2-1:0]     cross_r;
  logic [rv64_pkg::dword_width_lp/2-1:0]     a_lo;
  logic [rv64_pkg::dword_width_lp/2-1:0]     a_hi;
  logic [rv64_pkg::dword_width_lp/2-1:0]     b_lo;
  logic [rv64_pkg::dword_width_lp/2-1:0]     b_hi;

  assign {a_hi, a_lo} = a_r;
  assign {b_hi, b_lo} = b_r;

  // Low product needs lo*lo plus the low halves of the two cross terms;
  // hi*hi falls entirely above bit 63
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      a_r       <= '0;
      b_r       <= '0;
      lo_prod_r <= '0;
      cross_r   <= '0;
      data_o    <= '0;
    end
    else
    begin
      // Operand capture
      a_r       <= rs1_i;
      b_r       <= rs2_i;
      // Partial products
      lo_prod_r <= rv64_pkg::dword_t'(a_lo) * rv64_pkg::dword_t'(b_lo);
      cross_r   <= (a_lo * b_hi) + (a_hi * b_lo);
      // Final sum
      data_o    <= lo_prod_r + {cross_r, {(rv64_pkg::dword_width_lp/2){1'b0}}};
    end
  end

endmodule

`default_nettype wire

// File: completion_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module completion_pipe
  (input  wire                                             clk_i,
   input  wire                                             arst_n_i,
   input  logic                                            dispatch_v_i,
   input  calc_pkg::alu_op_e                               dispatch_op_i,
   input  rv64_pkg::reg_addr_t                             dispatch_rd_addr_i,
   input  logic                                            dispatch_irf_w_i,
   input  logic                                            flush_i,
   input  rv64_pkg::dword_t                                int_data_i,
   input  rv64_pkg::dword_t                                mul_data_i,
   output logic                [calc_pkg::comp_stages_lp:1] fwd_v_o,
   output rv64_pkg::reg_addr_t [calc_pkg::comp_stages_lp:1] fwd_rd_addr_o,
   output rv64_pkg::dword_t    [calc_pkg::comp_stages_lp:1] fwd_data_o,
   output logic                                            wb_v_o,
   output rv64_pkg::reg_addr_t                             wb_rd_addr_o,
   output rv64_pkg::dword_t                                wb_rd_data_o
  );

  // Index 0 is the reservation slot, the last index is the writeback register
  calc_pkg::stage_meta_s meta_r [0:calc_pkg::comp_stages_lp];
  calc_pkg::stage_meta_s meta_n [0:calc_pkg::comp_stages_lp];

  // Stage 1 data comes straight from the registered ALU output
  rv64_pkg::dword_t data_r     [calc_pkg::int_latency_lp+1:calc_pkg::comp_stages_lp];
  rv64_pkg::dword_t stage_data [1:calc_pkg::comp_stages_lp];

  logic live;

  always_comb
  begin
    meta_n[0].valid   = dispatch_v_i;
    meta_n[0].poison  = flush_i;
    meta_n[0].is_mul  = (dispatch_op_i == calc_pkg::op_mul);
    meta_n[0].irf_w   = dispatch_irf_w_i;
    meta_n[0].rd_addr = dispatch_rd_addr_i;
    for (int k = 1; k <= calc_pkg::comp_stages_lp; k++)
    begin
      meta_n[k] = meta_r[k-1];
      // Whatever is entering writeback on a flush edge still retires
      if (k < calc_pkg::wb_latency_lp)
      begin
        meta_n[k].poison = meta_r[k-1].poison | flush_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int k = 0; k <= calc_pkg::comp_stages_lp; k++)
      begin
        meta_r[k] <= '0;
      end
    end
    else
    begin
      for (int k = 0; k <= calc_pkg::comp_stages_lp; k++)
      begin
        meta_r[k] <= meta_n[k];
      end
    end
  end

  always_comb
  begin
    stage_data[calc_pkg::int_latency_lp] = int_data_i;
    for (int k = calc_pkg::int_latency_lp + 1; k <= calc_pkg::comp_stages_lp; k++)
    begin
      stage_data[k] = data_r[k];
    end
    if (meta_r[calc_pkg::mul_latency_lp].is_mul)
    begin
      stage_data[calc_pkg::mul_latency_lp] = mul_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int k = calc_pkg::int_latency_lp + 1; k <= calc_pkg::comp_stages_lp; k++)
    begin
      data_r[k] <= stage_data[k-1];
    end
  end

  // rd_addr reads x0 for dead stages so the bypass can spot pending ones
  always_comb
  begin
    for (int k = 1; k <= calc_pkg::comp_stages_lp; k++)
    begin
      live             = meta_r[k].valid & ~meta_r[k].poison & meta_r[k].irf_w;
      fwd_v_o[k]       = live & (meta_r[k].is_mul ? (k >= calc_pkg::mul_latency_lp)
                                                  : (k >= calc_pkg::int_latency_lp));
      fwd_rd_addr_o[k] = live ? meta_r[k].rd_addr : rv64_pkg::x0_addr_lp;
      fwd_data_o[k]    = stage_data[k];
    end
  end

  assign wb_v_o       = meta_r[calc_pkg::wb_latency_lp].valid
                        & ~meta_r[calc_pkg::wb_latency_lp].poison
                        & meta_r[calc_pkg::wb_latency_lp].irf_w
                        & (meta_r[calc_pkg::wb_latency_lp].rd_addr != rv64_pkg::x0_addr_lp);
  assign wb_rd_addr_o = meta_r[calc_pkg::wb_latency_lp].rd_addr;
  assign wb_rd_data_o = data_r[calc_pkg::wb_latency_lp];

  // A flush leaves the next wb_latency_lp writeback slots empty
  a_flush_kills_younger : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> ##1 (!wb_v_o) [*calc_pkg::wb_latency_lp])
    else $error("completion_pipe: flushed instruction reached writeback");

endmodule

`default_nettype wire

// File: calculator_top.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_top
  (input  wire                 clk_i,
   input  wire                 arst_n_i,
   input  logic                dispatch_v_i,
   input  calc_pkg::alu_op_e   dispatch_op_i,
   input  rv64_pkg::reg_addr_t dispatch_rd_addr_i,
   input  logic                dispatch_irf_w_i,
   input  rv64_pkg::reg_addr_t dispatch_rs1_addr_i,
   input  rv64_pkg::reg_addr_t dispatch_rs2_addr_i,
   input  rv64_pkg::dword_t    dispatch_rs1_i,
   input  rv64_pkg::dword_t    dispatch_rs2_i,
   input  logic                flush_i,
   output logic                wb_v_o,
   output rv64_pkg::reg_addr_t wb_rd_addr_o,
   output rv64_pkg::dword_t    wb_rd_data_o
  );

  // Forwarding network, stage 1 is the youngest
  logic                [calc_pkg::comp_stages_lp:1] fwd_v;
  rv64_pkg::reg_addr_t [calc_pkg::comp_stages_lp:1] fwd_rd_addr;
  rv64_pkg::dword_t    [calc_pkg::comp_stages_lp:1] fwd_data;

  calc_pkg::alu_op_e rsv_op;
  rv64_pkg::dword_t  rsv_rs1;
  rv64_pkg::dword_t  rsv_rs2;
  rv64_pkg::dword_t  int_data;
  rv64_pkg::dword_t  mul_data;

  operand_bypass bypass_i
    (.clk_i               (clk_i),
     .arst_n_i            (arst_n_i),
     .dispatch_op_i       (dispatch_op_i),
     .dispatch_rs1_addr_i (dispatch_rs1_addr_i),
     .dispatch_rs2_addr_i (dispatch_rs2_addr_i),
     .dispatch_rs1_i      (dispatch_rs1_i),
     .dispatch_rs2_i      (dispatch_rs2_i),
     .fwd_v_i             (fwd_v),
     .fwd_rd_addr_i       (fwd_rd_addr),
     .fwd_data_i          (fwd_data),
     .rsv_op_o            (rsv_op),
     .rsv_rs1_o           (rsv_rs1),
     .rsv_rs2_o           (rsv_rs2)
    );

  // Both pipes see every reservation entry, the completion pipe picks the result
  pipe_int pipe_int_i
    (.clk_i    (clk_i),
     .arst_n_i (arst_n_i),
     .op_i     (rsv_op),
     .rs1_i    (rsv_rs1),
     .rs2_i    (rsv_rs2),
     .data_o   (int_data)
    );

  pipe_mul pipe_mul_i
    (.clk_i    (clk_i),
     .arst_n_i (arst_n_i),
     .rs1_i    (rsv_rs1),
     .rs2_i    (rsv_rs2),
     .data_o   (mul_data)
    );

  completion_pipe completion_i
    (.clk_i              (clk_i),
     .arst_n_i           (arst_n_i),
     .dispatch_v_i       (dispatch_v_i),
     .dispatch_op_i      (dispatch_op_i),
     .dispatch_rd_addr_i (dispatch_rd_addr_i),
     .dispatch_irf_w_i   (dispatch_irf_w_i),
     .flush_i            (flush_i),
     .int_data_i         (int_data),
     .mul_data_i         (mul_data),
     .fwd_v_o            (fwd_v),
     .fwd_rd_addr_o      (fwd_rd_addr),
     .fwd_data_o         (fwd_data),
     .wb_v_o             (wb_v_o),
     .wb_rd_addr_o       (wb_rd_addr_o),
     .wb_rd_data_o       (wb_rd_data_o)
    );

endmodule

`default_nettype wire

// File: tb_calculator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_calculator;

  localparam int clk_period_lp  = 40;
  localparam int num_entries_lp = 38;

  // One dispatch followed by gap idle cycles
  typedef struct packed
  {
    calc_pkg::alu_op_e   op;
    rv64_pkg::reg_addr_t rd;
    rv64_pkg::reg_addr_t rs1;
    rv64_pkg::reg_addr_t rs2;
    logic                irf_w;
    logic                flush;
    logic [3:0]          gap;
  } entry_t;

  // A dispatched instruction waiting for its writeback slot
  typedef struct
  {
    calc_pkg::alu_op_e   op;
    rv64_pkg::reg_addr_t rd;
    rv64_pkg::reg_addr_t rs1;
    rv64_pkg::reg_addr_t rs2;
    logic                irf_w;
    logic                killed;
    int                  sample;
  } inflight_t;

  // Integer consumers sit two or more slots behind their producer
  // and multiply consumers four or more
  localparam entry_t stim_table [num_entries_lp] = '{
    // Every ALU operation on settled registers
    '{calc_pkg::op_add, 5'd1,  5'd2,  5'd3,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_sub, 5'd4,  5'd5,  5'd6,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_and, 5'd7,  5'd8,  5'd9,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_or,  5'd10, 5'd11, 5'd12, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_xor, 5'd13, 5'd14, 5'd15, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_sll, 5'd16, 5'd17, 5'd18, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_srl, 5'd19, 5'd20, 5'd21, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_slt, 5'd22, 5'd23, 5'd24, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_slt, 5'd25, 5'd24, 5'd23, 1'b1, 1'b0, 4'd0},
    // Back-to-back multiplies and then a consumer of two of them
    '{calc_pkg::op_mul, 5'd26, 5'd2,  5'd3,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_mul, 5'd27, 5'd5,  5'd6,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_mul, 5'd28, 5'd8,  5'd9,  1'b1, 1'b0, 4'd3},
    '{calc_pkg::op_add, 5'd29, 5'd28, 5'd27, 1'b1, 1'b0, 4'd0},
    // r30 is read from stages 1 to 4
    '{calc_pkg::op_xor, 5'd30, 5'd14, 5'd15, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_or,  5'd31, 5'd11, 5'd12, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_add, 5'd2,  5'd30, 5'd4,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_sub, 5'd3,  5'd30, 5'd1,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_and, 5'd5,  5'd30, 5'd31, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_sll, 5'd6,  5'd30, 5'd2,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_add, 5'd7,  5'd2,  5'd3,  1'b1, 1'b0, 4'd0},
    // Two writers of r9 in flight and the younger one must win
    '{calc_pkg::op_add, 5'd9,  5'd1,  5'd4,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_sub, 5'd9,  5'd1,  5'd4,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_or,  5'd10, 5'd13, 5'd16, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_add, 5'd11, 5'd9,  5'd9,  1'b1, 1'b0, 4'd5},
    // Flush on the fifth dispatch kills it and the three before it
    '{calc_pkg::op_add, 5'd12, 5'd1,  5'd2,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_sub, 5'd13, 5'd1,  5'd2,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_mul, 5'd14, 5'd3,  5'd5,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_xor, 5'd15, 5'd6,  5'd7,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_or,  5'd16, 5'd8,  5'd10, 1'b1, 1'b1, 4'd0},
    '{calc_pkg::op_add, 5'd17, 5'd12, 5'd13, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_and, 5'd18, 5'd14, 5'd15, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_or,  5'd19, 5'd16, 5'd12, 1'b1, 1'b0, 4'd3},
    // x0 sources, rd x0 and irf_w low
    '{calc_pkg::op_add, 5'd20, 5'd0,  5'd0,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_add, 5'd0,  5'd1,  5'd2,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_sub, 5'd21, 5'd1,  5'd2,  1'b0, 1'b0, 4'd0},
    '{calc_pkg::op_or,  5'd22, 5'd0,  5'd21, 1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_xor, 5'd23, 5'd21, 5'd0,  1'b1, 1'b0, 4'd0},
    '{calc_pkg::op_mul, 5'd24, 5'd20, 5'd3,  1'b1, 1'b0, 4'd4}
  };

  logic                clk_i;
  logic                arst_n_i;
  logic                dispatch_v_i;
  calc_pkg::alu_op_e   dispatch_op_i;
  rv64_pkg::reg_addr_t dispatch_rd_addr_i;
  logic                dispatch_irf_w_i;
  rv64_pkg::reg_addr_t dispatch_rs1_addr_i;
  rv64_pkg::reg_addr_t dispatch_rs2_addr_i;
  rv64_pkg::dword_t    dispatch_rs1_i;
  rv64_pkg::dword_t    dispatch_rs2_i;
  logic                flush_i;
  logic                wb_v_o;
  rv64_pkg::reg_addr_t wb_rd_addr_o;
  rv64_pkg::dword_t    wb_rd_data_o;

  // Committed register state that only moves at writeback
  rv64_pkg::dword_t ref_rf [32];
  inflight_t        inflight_q [$];
  logic [31:0]      rng_state = 32'h4f6d_48ae;
  int               edges     = 0;
  int               checks    = 0;
  int               errors    = 0;

  calculator_top dut_i
    (.clk_i               (clk_i),
     .arst_n_i            (arst_n_i),
     .dispatch_v_i        (dispatch_v_i),
     .dispatch_op_i       (dispatch_op_i),
     .dispatch_rd_addr_i  (dispatch_rd_addr_i),
     .dispatch_irf_w_i    (dispatch_irf_w_i),
     .dispatch_rs1_addr_i (dispatch_rs1_addr_i),
     .dispatch_rs2_addr_i (dispatch_rs2_addr_i),
     .dispatch_rs1_i      (dispatch_rs1_i),
     .dispatch_rs2_i      (dispatch_rs2_i),
     .flush_i             (flush_i),
     .wb_v_o              (wb_v_o),
     .wb_rd_addr_o        (wb_rd_addr_o),
     .wb_rd_data_o        (wb_rd_data_o)
    );

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Stale register value as the dispatcher would read it and junk for x0
  function automatic rv64_pkg::dword_t operand_value(input rv64_pkg::reg_addr_t addr);
    if (addr == rv64_pkg::x0_addr_lp)
    begin
      return {next_random(), next_random()};
    end
    return ref_rf[addr];
  endfunction

  function automatic rv64_pkg::dword_t source_value(input rv64_pkg::reg_addr_t addr);
    if (addr == rv64_pkg::x0_addr_lp)
    begin
      return '0;
    end
    return ref_rf[addr];
  endfunction

  function automatic rv64_pkg::dword_t compute_expected(input calc_pkg::alu_op_e op,
                                                        input rv64_pkg::dword_t  a,
                                                        input rv64_pkg::dword_t  b);
    case (op)
      calc_pkg::op_add: return a + b;
      calc_pkg::op_sub: return a - b;
      calc_pkg::op_and: return a & b;
      calc_pkg::op_or:  return a | b;
      calc_pkg::op_xor: return a ^ b;
      calc_pkg::op_sll: return a << b[rv64_pkg::shamt_width_lp-1:0];
      calc_pkg::op_srl: return a >> b[rv64_pkg::shamt_width_lp-1:0];
      calc_pkg::op_slt: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      calc_pkg::op_mul: return a * b;
      default:          return '0;
    endcase
  endfunction

  task automatic check_wb_valid(input logic actual, input logic expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH wb_v_o: got %h, expected %h at %0t", actual, expected, $time);
    end
  endtask

  task automatic check_wb_addr(input rv64_pkg::reg_addr_t actual,
                               input rv64_pkg::reg_addr_t expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH wb_rd_addr_o: got %h, expected %h at %0t", actual, expected, $time);
    end
  endtask

  task automatic check_wb_data(input rv64_pkg::dword_t actual,
                               input rv64_pkg::dword_t expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH wb_rd_data_o: got %h, expected %h at %0t", actual, expected, $time);
    end
  endtask

  // Evaluated in program order, so every older survivor is already committed
  task automatic retire(input inflight_t rec);
    rv64_pkg::dword_t expected;
    if (rec.killed || !rec.irf_w || (rec.rd == rv64_pkg::x0_addr_lp))
    begin
      check_wb_valid(wb_v_o, 1'b0);
    end
    else
    begin
      expected = compute_expected(rec.op, source_value(rec.rs1), source_value(rec.rs2));
      check_wb_valid(wb_v_o, 1'b1);
      check_wb_addr(wb_rd_addr_o, rec.rd);
      check_wb_data(wb_rd_data_o, expected);
      ref_rf[rec.rd] = expected;
    end
  endtask

  task automatic drive_entry(input entry_t e);
    inflight_t rec;
    rec.op     = e.op;
    rec.rd     = e.rd;
    rec.rs1    = e.rs1;
    rec.rs2    = e.rs2;
    rec.irf_w  = e.irf_w;
    rec.killed = e.flush;
    rec.sample = edges + 2;
    // Flush also takes the dispatches that are not yet in writeback
    if (e.flush)
    begin
      foreach (inflight_q[k])
      begin
        if (inflight_q[k].sample >= rec.sample - (calc_pkg::wb_latency_lp - 1))
        begin
          inflight_q[k].killed = 1'b1;
        end
      end
    end
    inflight_q.push_back(rec);
    dispatch_v_i        <= 1'b1;
    dispatch_op_i       <= e.op;
    dispatch_rd_addr_i  <= e.rd;
    dispatch_irf_w_i    <= e.irf_w;
    dispatch_rs1_addr_i <= e.rs1;
    dispatch_rs2_addr_i <= e.rs2;
    dispatch_rs1_i      <= operand_value(e.rs1);
    dispatch_rs2_i      <= operand_value(e.rs2);
    flush_i             <= e.flush;
  endtask

  task automatic drive_idle();
    dispatch_v_i        <= 1'b0;
    dispatch_op_i       <= calc_pkg::op_add;
    dispatch_rd_addr_i  <= rv64_pkg::x0_addr_lp;
    dispatch_irf_w_i    <= 1'b0;
    dispatch_rs1_addr_i <= rv64_pkg::x0_addr_lp;
    dispatch_rs2_addr_i <= rv64_pkg::x0_addr_lp;
    dispatch_rs1_i      <= '0;
    dispatch_rs2_i      <= '0;
    flush_i             <= 1'b0;
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    edges <= edges + 1;
  end

  // Writeback outputs are stable mid-cycle
  always @(negedge clk_i)
  begin
    if ((inflight_q.size() != 0)
        && (inflight_q[0].sample + calc_pkg::wb_latency_lp == edges))
    begin
      retire(inflight_q.pop_front());
    end
    else
    begin
      check_wb_valid(wb_v_o, 1'b0);
    end
  end

  initial
  begin
    ref_rf[0] = '0;
    for (int r = 1; r < 32; r++)
    begin
      ref_rf[r] = {next_random(), next_random()};
    end
    arst_n_i            = 1'b0;
    dispatch_v_i        = 1'b0;
    dispatch_op_i       = calc_pkg::op_add;
    dispatch_rd_addr_i  = rv64_pkg::x0_addr_lp;
    dispatch_irf_w_i    = 1'b0;
    dispatch_rs1_addr_i = rv64_pkg::x0_addr_lp;
    dispatch_rs2_addr_i = rv64_pkg::x0_addr_lp;
    dispatch_rs1_i      = '0;
    dispatch_rs2_i      = '0;
    flush_i             = 1'b0;
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < num_entries_lp; i++)
    begin
      drive_entry(stim_table[i]);
      @(posedge clk_i);
      repeat (stim_table[i].gap)
      begin
        drive_idle();
        @(posedge clk_i);
      end
    end
    drive_idle();
    repeat (calc_pkg::wb_latency_lp + 2) @(posedge clk_i);
    $display("tb_calculator: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog allows twice the longest possible run
  initial
  begin
    int     max_gap;
    longint limit_ns;
    max_gap = 0;
    for (int i = 0; i < num_entries_lp; i++)
    begin
      if (int'(stim_table[i].gap) > max_gap)
      begin
        max_gap = int'(stim_table[i].gap);
      end
    end
    limit_ns = longint'((num_entries_lp * (max_gap + calc_pkg::wb_latency_lp) + 20)
                        * clk_period_lp * 2);
    #(limit_ns);
    $display("Watchdog expired after %0d ns before the stimulus finished", limit_ns);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
rv64_pkg.sv
calc_pkg.sv
operand_bypass.sv
pipe_int.sv
pipe_mul.sv
completion_pipe.sv
calculator_top.sv
tb_calculator.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_calculator
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = tests failed
PASS_MSG = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
